/* tb.f */
+incdir+verilog
verilog/elevator_pkg.sv
verilog/call_if.sv
verilog/service_if.sv
verilog/call_registry.sv
verilog/position_tracker.sv
verilog/travel_director.sv
verilog/door_sequencer.sv
verilog/elevator_controller.sv
test/tb_elevator.sv

/* Bender.yml */
package:
  name: elevator_controller

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/elevator_pkg.sv
      - verilog/call_if.sv
      - verilog/service_if.sv
      - verilog/call_registry.sv
      - verilog/position_tracker.sv
      - verilog/travel_director.sv
      - verilog/door_sequencer.sv
      - verilog/elevator_controller.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_elevator.sv

/* test/tb_elevator.sv */
`timescale 1ns/1ps
`include "elevator_defs.svh"

module tb_elevator import elevator_pkg::*; ();

    localparam int CLOCK_NS = 100;
    localparam int WAIT_LIMIT = 400;

    // Cycle budgets of the tests, summed for the watchdog
    localparam int RESET_CYCLES  = 10;
    localparam int SINGLE_CYCLES = 400;
    localparam int MULTI_CYCLES  = 2000;
    localparam int DOOR_CYCLES   = 600;
    localparam int POWER_CYCLES  = 1000;
    localparam int FAULT_CYCLES  = 300;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + SINGLE_CYCLES + MULTI_CYCLES +
                                     DOOR_CYCLES + POWER_CYCLES + FAULT_CYCLES + 500;

    logic                    clock = 1'b0;
    logic                    reset;
    logic [`FLOOR_COUNT-1:0] car_button;
    logic [`FLOOR_COUNT-2:0] hall_up;
    logic [`FLOOR_COUNT-1:1] hall_down;
    logic [`FLOOR_COUNT-1:0] floor_sensor;
    logic                    door_open_limit;
    logic                    door_closed_limit;
    logic                    open_button;
    logic                    close_button;
    logic                    power_ok;
    motor_dir_t              motor;
    motor_dir_t              door;
    logic                    alarm;
    logic [3:0]              display;

    // Car position in half floors, even means level with a floor
    int                      pos = 0;
    int                      move_timer = 0;
    int                      door_timer = 0;
    motor_dir_t              last_door = MOTOR_STOP;
    logic [`FLOOR_COUNT-1:0] plant_sensor;
    logic [`FLOOR_COUNT-1:0] sensor_force = '0;

    // Calls as the testbench pressed them
    logic [`FLOOR_COUNT-1:0] car_pend = '0;
    logic [`FLOOR_COUNT-1:0] up_pend = '0;
    logic [`FLOOR_COUNT-1:0] down_pend = '0;
    motor_dir_t              travel_dir = MOTOR_STOP;
    int                      expected_stop = -1;
    logic                    order_check = 1'b0;
    logic [31:0]             lfsr_state = 32'ha525_d834;
    int                      errors = 0;
    int                      tests_run = 0;
    int                      tests_failed = 0;

    elevator_controller u_dut (.*);

    always #(CLOCK_NS / 2) clock = ~clock;

    // ------------------------------
    // Shaft and door plant
    // ------------------------------

    always_comb begin
        plant_sensor = '0;
        if (pos % 2 == 0) begin
            plant_sensor[pos / 2] = 1'b1;
        end
    end

    assign floor_sensor = plant_sensor | sensor_force;

    always @(negedge clock) begin
        if (motor == MOTOR_STOP) begin
            move_timer <= 0;
        end else if (move_timer == 7) begin
            move_timer <= 0;
            if (motor == MOTOR_UP && pos < 2 * (`FLOOR_COUNT - 1)) pos <= pos + 1;
            if (motor == MOTOR_DOWN && pos > 0) pos <= pos - 1;
        end else begin
            move_timer <= move_timer + 1;
        end
    end

    // Limits follow the door command 4 cycles late
    always @(negedge clock) begin
        last_door <= door;
        if (door != last_door) door_timer <= 1;
        else if (door_timer < 15) door_timer <= door_timer + 1;
        if (door == MOTOR_UP) begin
            door_closed_limit <= 1'b0;
            if (door == last_door && door_timer >= 4) door_open_limit <= 1'b1;
        end else if (door == MOTOR_DOWN) begin
            door_open_limit <= 1'b0;
            if (door == last_door && door_timer >= 4) door_closed_limit <= 1'b1;
        end
    end

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int take_bits(input int count);
        int v;
        v = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    function automatic int other_floor();
        return (pos / 2 + 1 + take_bits(2)) % `FLOOR_COUNT;
    endfunction

    // Nearest call ahead, else the nearest behind; up wins with no direction yet
    function automatic int next_stop(input int at, input motor_dir_t dir,
                                     input logic [`FLOOR_COUNT-1:0] car,
                                     input logic [`FLOOR_COUNT-1:0] up,
                                     input logic [`FLOOR_COUNT-1:0] down);
        logic [`FLOOR_COUNT-1:0] want;
        int up_stop;
        int down_stop;
        want = car | up | down;
        up_stop = -1;
        down_stop = -1;
        if (want[at]) return at;
        for (int f = `FLOOR_COUNT - 1; f > at; f--) begin
            if (want[f]) up_stop = f;
        end
        for (int f = 0; f < at; f++) begin
            if (want[f]) down_stop = f;
        end
        if (up_stop >= 0 && !(dir == MOTOR_DOWN && down_stop >= 0)) return up_stop;
        return down_stop;
    endfunction

    task automatic wrong_value(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0d ns waiting for %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start);
        end
    endtask

    // ------------------------------
    // Arrival and motion checks
    // ------------------------------

    always @(negedge clock) begin
        if (!reset) begin
            if (motor != MOTOR_STOP && !door_closed_limit) begin
                wrong_value("motor running while the door is not closed");
            end
            if (motor == MOTOR_UP) begin
                travel_dir <= MOTOR_UP;
            end else if (motor == MOTOR_DOWN) begin
                travel_dir <= MOTOR_DOWN;
            end else if (door == MOTOR_STOP && door_closed_limit && pos % 2 == 0) begin
                if ((car_pend | up_pend | down_pend) == '0) travel_dir <= MOTOR_STOP;
                expected_stop <= next_stop(pos / 2, travel_dir, car_pend, up_pend, down_pend);
            end
            if (door == MOTOR_UP && last_door != MOTOR_UP && pos % 2 == 0) begin
                if (order_check && (pos / 2 != expected_stop || display != expected_stop)) begin
                    wrong_value($sformatf("stopped at floor %0d, display %0d, expected %0d",
                                          pos / 2, display, expected_stop));
                end
                car_pend[pos / 2]  <= 1'b0;
                up_pend[pos / 2]   <= 1'b0;
                down_pend[pos / 2] <= 1'b0;
            end
        end
    end

    task automatic press(input logic [`FLOOR_COUNT-1:0] car,
                         input logic [`FLOOR_COUNT-1:0] up,
                         input logic [`FLOOR_COUNT-1:0] down);
        car_button <= car;
        hall_up    <= up[`FLOOR_COUNT-2:0];
        hall_down  <= down[`FLOOR_COUNT-1:1];
        car_pend   <= car_pend | car;
        up_pend    <= up_pend | up;
        down_pend  <= down_pend | down;
        @(negedge clock);
        car_button <= '0;
        hall_up    <= '0;
        hall_down  <= '0;
    endtask

    task automatic tap_door_button(input logic open);
        if (open) open_button <= 1'b1;
        else close_button <= 1'b1;
        @(negedge clock);
        open_button  <= 1'b0;
        close_button <= 1'b0;
    endtask

    task automatic wait_door(input motor_dir_t want, input string what);
        int n;
        n = 0;
        @(negedge clock);
        while (door != want && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (door != want) report_timeout(what);
    endtask

    task automatic wait_motor_running();
        int n;
        n = 0;
        while (motor == MOTOR_STOP && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (motor == MOTOR_STOP) report_timeout("the car to start moving");
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        int start;
        int f;
        int n;
        int kind;
        logic [`FLOOR_COUNT-1:0] car_v;
        logic [`FLOOR_COUNT-1:0] up_v;
        logic [`FLOOR_COUNT-1:0] down_v;

        reset = 1'b1;
        car_button = '0;
        hall_up = '0;
        hall_down = '0;
        door_open_limit = 1'b0;
        door_closed_limit = 1'b1;
        open_button = 1'b0;
        close_button = 1'b0;
        power_ok = 1'b1;
        repeat (4) @(posedge clock);
        @(negedge clock);

        start = errors;
        if (motor != MOTOR_STOP || door != MOTOR_STOP || alarm || display != 0) begin
            wrong_value($sformatf("reset: motor %s door %s alarm %b display %0d",
                                  motor.name(), door.name(), alarm, display));
        end
        reset <= 1'b0;
        @(negedge clock);
        finish_test("reset_values", start);

        start = errors;
        order_check <= 1'b1;
        f = other_floor();
        car_v = '0;
        car_v[f] = 1'b1;
        press(car_v, '0, '0);
        wait_door(MOTOR_UP, "the door to open at the called floor");
        if (display != f) wrong_value($sformatf("display %0d at floor %0d", display, f));
        wait_door(MOTOR_DOWN, "the door to close");
        wait_door(MOTOR_STOP, "the door to stop closed");
        if (u_dut.calls.car_calls[f]) wrong_value("car call still pending after service");
        finish_test("single_call", start);

        start = errors;
        car_v = '0;
        up_v = '0;
        down_v = '0;
        for (int i = 0; i < 4; i++) begin
            f = take_bits(3) % `FLOOR_COUNT;
            kind = take_bits(2);
            if (kind == 2 && f < `FLOOR_COUNT - 1) up_v[f] = 1'b1;
            else if (kind == 3 && f > 0) down_v[f] = 1'b1;
            else car_v[f] = 1'b1;
        end
        press(car_v, up_v, down_v);
        n = 0;
        while (((car_pend | up_pend | down_pend) != '0 || door != MOTOR_STOP ||
                !door_closed_limit) && n < MULTI_CYCLES) begin
            @(negedge clock);
            n++;
        end
        if (n >= MULTI_CYCLES) report_timeout("all random calls to be served");
        order_check <= 1'b0;
        finish_test("collective_order", start);

        // Hold time, then close press and reopen while closing
        start = errors;
        tap_door_button(1'b1);
        wait_door(MOTOR_UP, "the door to open");
        wait_door(MOTOR_STOP, "the open limit");
        n = 0;
        while (door != MOTOR_DOWN && n < 2 * `DOOR_HOLD_CYCLES) begin
            @(negedge clock);
            n++;
        end
        if (n != `DOOR_HOLD_CYCLES) wrong_value($sformatf("door held open %0d cycles", n));
        wait_door(MOTOR_STOP, "the door to stop closed");
        tap_door_button(1'b1);
        wait_door(MOTOR_UP, "the door to open");
        wait_door(MOTOR_STOP, "the open limit");
        repeat (10) @(negedge clock);
        tap_door_button(1'b0);
        if (door != MOTOR_DOWN) wrong_value("close press did not end the hold");
        @(negedge clock);
        tap_door_button(1'b1);
        if (door != MOTOR_UP) wrong_value("open press did not reopen the closing door");
        wait_door(MOTOR_DOWN, "the door to close");
        wait_door(MOTOR_STOP, "the door to stop closed");
        finish_test("door_timing", start);

        start = errors;
        f = other_floor();
        car_v = '0;
        car_v[f] = 1'b1;
        press(car_v, '0, '0);
        wait_motor_running();
        power_ok <= 1'b0;
        for (int i = 0; i < 20; i++) begin
            @(negedge clock);
            if (motor != MOTOR_STOP || display != `FAULT_DISPLAY || alarm) begin
                wrong_value($sformatf("power low: motor %s display %h alarm %b",
                                      motor.name(), display, alarm));
            end
        end
        power_ok <= 1'b1;
        wait_door(MOTOR_UP, "the door to open after power returned");
        wait_door(MOTOR_STOP, "the open limit");
        power_ok <= 1'b0;
        @(negedge clock);
        if (door != MOTOR_DOWN) wrong_value("door not closing after power loss");
        wait_door(MOTOR_STOP, "the door to stop closed");
        if (!door_closed_limit || alarm || display != `FAULT_DISPLAY || motor != MOTOR_STOP) begin
            wrong_value("door, alarm, display or motor wrong with power low");
        end
        power_ok <= 1'b1;
        wait_door(MOTOR_UP, "the door to reopen");
        wait_door(MOTOR_DOWN, "the door to close");
        wait_door(MOTOR_STOP, "the door to stop closed");
        finish_test("power_loss", start);

        start = errors;
        f = other_floor();
        car_v = '0;
        car_v[f] = 1'b1;
        press(car_v, '0, '0);
        wait_motor_running();
        sensor_force <= 5'b10001;
        repeat (2) @(negedge clock);
        if (!alarm || motor != MOTOR_STOP || display != `FAULT_DISPLAY) begin
            wrong_value($sformatf("fault: alarm %b motor %s display %h",
                                  alarm, motor.name(), display));
        end
        sensor_force <= '0;
        repeat (10) @(negedge clock);
        if (!alarm || display != `FAULT_DISPLAY) wrong_value("alarm cleared without reset");
        reset <= 1'b1;
        repeat (4) @(negedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (alarm) wrong_value("alarm still set after reset");
        finish_test("sensor_fault", start);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_NS);
        $display("Watchdog expired before the tests completed");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* verilog/elevator_controller.sv */
`timescale 1ns/1ps
`include "elevator_defs.svh"

module elevator_controller import elevator_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [`FLOOR_COUNT-1:0]  car_button,
    input  logic [`FLOOR_COUNT-2:0]  hall_up,
    input  logic [`FLOOR_COUNT-1:1]  hall_down,
    input  logic [`FLOOR_COUNT-1:0]  floor_sensor,
    input  logic                     door_open_limit,
    input  logic                     door_closed_limit,
    input  logic                     open_button,
    input  logic                     close_button,
    input  logic                     power_ok,
    output motor_dir_t               motor,
    output motor_dir_t               door,
    output logic                     alarm,
    output logic [3:0]               display
);

    logic [`FLOOR_W-1:0]     floor;
    logic                    between;
    logic                    fault;
    logic                    enable;
    logic [`FLOOR_COUNT-1:0] car_request;

    call_if    calls ();
    service_if service ();

    // Open button at rest asks for a stop at the current floor
    always_comb begin
        car_request = car_button;
        if (open_button && motor == MOTOR_STOP && !between) begin
            car_request[floor] = 1'b1;
        end
    end

    call_registry u_calls (
        .clock, .reset, .car_button(car_request), .hall_up, .hall_down, .calls(calls.registry)
    );

    position_tracker u_position (
        .clock, .reset, .floor_sensor, .motor, .floor, .between, .fault
    );

    travel_director u_director (
        .clock, .reset, .enable, .floor, .between,
        .calls(calls.director), .service(service.director), .motor
    );

    door_sequencer u_door (
        .clock, .reset, .enable, .open_button, .close_button, .door_open_limit,
        .door_closed_limit, .service(service.door), .calls(calls.door), .door
    );

    // ------------------------------
    // Alarm and display
    // ------------------------------

    always_ff @(posedge clock or posedge reset) begin
        if (reset) alarm <= 1'b0;
        else if (fault) alarm <= 1'b1;
    end

    // Power loss halts the car without raising the alarm
    assign enable  = power_ok && !alarm && !fault;
    assign display = enable ? 4'(floor) : `FAULT_DISPLAY;

endmodule

/* verilog/door_sequencer.sv */
`timescale 1ns/1ps
`include "elevator_defs.svh"

module door_sequencer import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        enable,
    input  logic        open_button,
    input  logic        close_button,
    input  logic        door_open_limit,
    input  logic        door_closed_limit,
    service_if.door     service,
    call_if.door        calls,
    output motor_dir_t  door
);

    localparam int HOLD_W = $clog2(`DOOR_HOLD_CYCLES + 1);
    localparam logic [HOLD_W-1:0] HOLD_LAST = `DOOR_HOLD_CYCLES - 1;

    door_state_t         state;
    logic [HOLD_W-1:0]   hold_count;
    logic [`FLOOR_W-1:0] stop_floor;

    assign service.ready = (state == DOOR_IDLE) && enable;

    // End of a cycle: the closed limit reached while closing
    assign service.done     = (state == DOOR_CLOSING) && door_closed_limit && enable;
    assign calls.clear      = service.done;
    assign calls.clear_floor = stop_floor;

    always_ff @(posedge clock) begin
        if (service.valid && service.ready) stop_floor <= service.floor;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= DOOR_IDLE;
            door       <= MOTOR_STOP;
            hold_count <= '0;
        end else if (!enable) begin
            // Shut the door and stay shut
            hold_count <= '0;
            if (door_closed_limit) begin
                state <= DOOR_IDLE;
                door  <= MOTOR_STOP;
            end else begin
                state <= DOOR_CLOSING;
                door  <= MOTOR_DOWN;
            end
        end else begin
            case (state)
                DOOR_IDLE: begin
                    door <= MOTOR_STOP;
                    if (service.valid) begin
                        state <= DOOR_OPENING;
                        door  <= MOTOR_UP;
                    end
                end
                DOOR_OPENING: begin
                    if (door_open_limit) begin
                        state      <= DOOR_HOLDING;
                        door       <= MOTOR_STOP;
                        hold_count <= '0;
                    end
                end
                DOOR_HOLDING: begin
                    if (close_button || hold_count == HOLD_LAST) begin
                        state <= DOOR_CLOSING;
                        door  <= MOTOR_DOWN;
                    end else if (open_button) begin
                        hold_count <= '0;
                    end else begin
                        hold_count <= hold_count + 1'b1;
                    end
                end
                DOOR_CLOSING: begin
                    if (open_button) begin
                        state <= DOOR_OPENING;
                        door  <= MOTOR_UP;
                    end else if (door_closed_limit) begin
                        state <= DOOR_IDLE;
                        door  <= MOTOR_STOP;
                    end
                end
                default: begin
                    state <= DOOR_IDLE;
                    door  <= MOTOR_STOP;
                end
            endcase
        end
    end

    // Done lasts a single cycle per door cycle
    a_done_pulse: assert property (@(posedge clock) disable iff (reset)
        service.done |=> !service.done)
        else $error("done held longer than one cycle");

endmodule

/* verilog/travel_director.sv */
`timescale 1ns/1ps
`include "elevator_defs.svh"

module travel_director import elevator_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 enable,
    input  logic [`FLOOR_W-1:0]  floor,
    input  logic                 between,
    call_if.director             calls,
    service_if.director          service,
    output motor_dir_t           motor
);

    localparam logic [`FLOOR_W-1:0] TOP_FLOOR = `FLOOR_COUNT - 1;

    logic [`FLOOR_COUNT-1:0] pending;
    logic                    above;
    logic                    below;
    logic                    go_up;
    logic                    go_down;
    logic                    serving;
    motor_dir_t              dir;

    assign pending = calls.car_calls | calls.up_calls | calls.down_calls;

    always_comb begin
        above = 1'b0;
        below = 1'b0;
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            if (pending[i] && i > floor) above = 1'b1;
            if (pending[i] && i < floor) below = 1'b1;
        end
    end

    // Collective rule: keep going while a call lies ahead
    assign go_up   = above && (dir != MOTOR_DOWN || !below);
    assign go_down = below && !go_up;

    assign service.floor = floor;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            motor         <= MOTOR_STOP;
            dir           <= MOTOR_STOP;
            service.valid <= 1'b0;
            serving       <= 1'b0;
        end else if (!enable) begin
            motor         <= MOTOR_STOP;
            service.valid <= 1'b0;
            serving       <= 1'b0;
        end else if (serving) begin
            motor <= MOTOR_STOP;
            if (service.done) serving <= 1'b0;
        end else if (service.valid) begin
            motor <= MOTOR_STOP;
            if (service.ready) begin
                service.valid <= 1'b0;
                serving       <= 1'b1;
            end
        end else if (between) begin
            motor <= dir;
        end else if (pending[floor]) begin
            motor         <= MOTOR_STOP;
            service.valid <= 1'b1;
        end else if (go_up) begin
            motor <= MOTOR_UP;
            dir   <= MOTOR_UP;
        end else if (go_down) begin
            motor <= MOTOR_DOWN;
            dir   <= MOTOR_DOWN;
        end else begin
            motor <= MOTOR_STOP;
            dir   <= MOTOR_STOP;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    a_top_limit: assert property (@(posedge clock) disable iff (reset)
        (floor == TOP_FLOOR && !between) |=> motor != MOTOR_UP)
        else $error("motor up at the top floor");

    a_bottom_limit: assert property (@(posedge clock) disable iff (reset)
        (floor == '0 && !between) |=> motor != MOTOR_DOWN)
        else $error("motor down at floor 1");

    // A stop request stays up until the door takes it
    a_valid_held: assert property (@(posedge clock) disable iff (reset)
        (service.valid && !service.ready && enable) |=> service.valid)
        else $error("stop request dropped before the door took it");

endmodule

/* verilog/position_tracker.sv */
`timescale 1ns/1ps
`include "elevator_defs.svh"

module position_tracker import elevator_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [`FLOOR_COUNT-1:0]  floor_sensor,
    input  motor_dir_t               motor,
    output logic [`FLOOR_W-1:0]      floor,
    output logic                     between,
    output logic                     fault
);

    logic [`FLOOR_W-1:0] hot_count;
    logic [`FLOOR_W-1:0] hot_index;
    logic                step_ok;

    always_comb begin
        hot_count = '0;
        hot_index = '0;
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            if (floor_sensor[i]) begin
                hot_count = hot_count + 1'b1;
                hot_index = i[`FLOOR_W-1:0];
            end
        end
    end

    // A moving car can only reach the floor next to the one it left
    assign step_ok = (motor == MOTOR_STOP) || (hot_index == floor) ||
                     (hot_index == floor + 1'b1) || (hot_index == floor - 1'b1);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            floor   <= '0;
            between <= 1'b0;
            fault   <= 1'b0;
        end else if (hot_count == '0) begin
            between <= 1'b1;
            fault   <= 1'b0;
        end else if (hot_count == 1) begin
            floor   <= hot_index;
            between <= 1'b0;
            fault   <= !step_ok;
        end else begin
            // Several sensors lit at once
            fault   <= 1'b1;
        end
    end

    a_floor_range: assert property (
        @(posedge clock) disable iff (reset)
        floor < `FLOOR_COUNT
    ) else $error("floor index out of range");

endmodule

/* verilog/call_registry.sv */
`timescale 1ns/1ps
`include "elevator_defs.svh"

module call_registry (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [`FLOOR_COUNT-1:0]  car_button,
    input  logic [`FLOOR_COUNT-2:0]  hall_up,
    input  logic [`FLOOR_COUNT-1:1]  hall_down,
    call_if.registry                 calls
);

    logic [`FLOOR_COUNT-1:0] served;
    logic [`FLOOR_COUNT-1:0] up_press;
    logic [`FLOOR_COUNT-1:0] down_press;

    // No up button on the top floor and no down button on floor 1
    assign up_press   = {1'b0, hall_up};
    assign down_press = {hall_down, 1'b0};

    always_comb begin
        served = '0;
        if (calls.clear) begin
            served[calls.clear_floor] = 1'b1;
        end
    end

    // ------------------------------
    // Call flags
    // ------------------------------

    // A press in the clear cycle loses to the clear
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            calls.car_calls  <= '0;
            calls.up_calls   <= '0;
            calls.down_calls <= '0;
        end else begin
            calls.car_calls  <= (calls.car_calls | car_button) & ~served;
            calls.up_calls   <= (calls.up_calls | up_press) & ~served;
            calls.down_calls <= (calls.down_calls | down_press) & ~served;
        end
    end

    a_no_edge_calls: assert property (
        @(posedge clock) disable iff (reset)
        !calls.up_calls[`FLOOR_COUNT-1] && !calls.down_calls[0]
    ) else $error("call flag set for a missing hall button");

endmodule

/* verilog/service_if.sv */
`timescale 1ns/1ps
`include "elevator_defs.svh"

interface service_if;

    // Stop request from the director, held until ready
    logic                valid;
    logic [`FLOOR_W-1:0] floor;

    // Door side; done marks the end of a door cycle
    logic                ready;
    logic                done;

    modport director (output valid, floor, input ready, done);
    modport door (input valid, floor, output ready, done);

endinterface

/* verilog/call_if.sv */
`timescale 1ns/1ps
`include "elevator_defs.svh"

interface call_if;

    // Pending calls, one bit per floor
    logic [`FLOOR_COUNT-1:0] car_calls;
    logic [`FLOOR_COUNT-1:0] up_calls;
    logic [`FLOOR_COUNT-1:0] down_calls;

    // Served floor, drops every call there
    logic                    clear;
    logic [`FLOOR_W-1:0]     clear_floor;

    modport registry (output car_calls, up_calls, down_calls, input clear, clear_floor);
    modport director (input car_calls, up_calls, down_calls);
    modport door (output clear, clear_floor);

endinterface

/* verilog/elevator_pkg.sv */
package elevator_pkg;

    // Motor command; the door drive reuses it
    // with up as open and down as close
    typedef enum logic [1:0] {
        MOTOR_STOP = 2'b00,
        MOTOR_UP   = 2'b01,
        MOTOR_DOWN = 2'b10
    } motor_dir_t;

    // Door cycle at a stop
    typedef enum logic [2:0] {
        DOOR_IDLE    = 3'd0,
        DOOR_OPENING = 3'd1,
        DOOR_HOLDING = 3'd2,
        DOOR_CLOSING = 3'd3
    } door_state_t;

endpackage

/* verilog/elevator_defs.svh */
`ifndef ELEVATOR_DEFS_SVH
`define ELEVATOR_DEFS_SVH

// ------------------------------
// Shaft geometry
// ------------------------------

// Floors served by the car, numbered 0 upward
`define FLOOR_COUNT 5

// Bits needed for a floor index
`define FLOOR_W 3

// ------------------------------
// Door and display
// ------------------------------

// Clock edges the door stays fully open
`define DOOR_HOLD_CYCLES 50

`define FAULT_DISPLAY 4'hA

`endif
